// ==== cpuBusTop.f ====
verilog/cpuIsaPkg.sv
verilog/cpuBusPkg.sv
verilog/datapathCtrl.sv
verilog/stepCounter.sv
verilog/controlSequencer.sv
verilog/registerFile.sv
verilog/aluStage.sv
verilog/busDatapath.sv
verilog/cpuBusTop.sv
sim/cpuBusTb.sv

// ==== Makefile ====
# Verilator build and run of the single-bus CPU testbench

TOP = cpuBusTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f cpuBusTop.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f cpuBusTop.f

clean:
	rm -rf obj_dir

// ==== sim/cpuVectors.txt ====
# M <address> <word>   memory image, both hex
# E <register> <value> expected register value after HALT, both hex
M 0000 68800F0F
M 0001 6907FF00
M 0002 51890000
M 0003 5A090000
M 0004 6293F0F0
M 0005 6B000040
M 0006 03B00010
M 0007 0437FFF8
M 0008 64A7FFF0
M 0009 5BB98000
M 000A F8000000
M 0038 12345678
M 0050 CAFEF00D
E 0 00000000
E 1 00000F0F
E 2 FFFFFF00
E 3 00000F00
E 4 FFFFFF0F
E 5 0003F000
E 6 00000040
E 7 CAFEFF0D
E 8 12345678
E 9 FFFFFF00
E A 00000000
E F 00000000

// ==== sim/cpuBusTb.sv ====
`timescale 1ns/1ps

module cpuBusTb;

	localparam int AddrWidth = 16;
	localparam int PostHaltCycles = 20;

	logic                 Clock = 1'b0;
	logic                 rstN;
	logic                 run;
	logic [31:0]          memData;
	logic [3:0]           dbgSel;
	logic [AddrWidth-1:0] memAddr;
	logic                 memRead;
	logic [AddrWidth-1:0] pc;
	logic                 halted;
	logic [31:0]          dbgData;

	logic [31:0]          mem [int];     // sparse program and data image
	logic [31:0]          expReg [16];
	logic                 expValid [16];
	logic [AddrWidth-1:0] expAddr [$];   // fetch and load addresses in order
	int                   expCycles;
	int                   haltAddr;
	int                   idleGap;
	int                   timeoutLimit;
	int                   cycleCount;
	int                   t0Cycle;
	int                   readIdx;
	logic                 lastMemRead;
	logic                 haltSeen;
	int                   mismatchCount;
	int                   failureCount;

	cpuBusTop #(
		.AddrWidth (AddrWidth)
	) u_cpuBusTop (
		.Clock   (Clock),
		.rstN    (rstN),
		.run     (run),
		.memData (memData),
		.dbgSel  (dbgSel),
		.memAddr (memAddr),
		.memRead (memRead),
		.pc      (pc),
		.halted  (halted),
		.dbgData (dbgData)
	);

	always #20 Clock = ~Clock;

	function automatic logic [31:0] memWord(input logic [AddrWidth-1:0] addr);
		if (mem.exists(int'(addr)))
			return mem[int'(addr)];
		return {~addr, addr};   // unloaded words differ at every address
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		mismatchCount++;
		$display("** Error at %0d ns: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
	endtask

	task automatic reportFailure(input string what);
		failureCount++;
		$display("** Error at %0d ns: %s", $time, what);
	endtask

	task automatic printSummary();
		$display("mismatches: %0d, other failures: %0d", mismatchCount, failureCount);
	endtask

	task automatic readVectors();
		int               fd;
		int               c;
		int               n;
		int               addrVal;
		int               regVal;
		logic [31:0]      wordVal;
		logic [8*128-1:0] lineBuf;
		for (int i = 0; i < 16; i++)
			expValid[i] = 1'b0;
		fd = $fopen("sim/cpuVectors.txt", "r");
		if (fd == 0) begin
			reportFailure("cannot open sim/cpuVectors.txt");
			return;
		end
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "M") begin
				n = $fscanf(fd, "%h %h", addrVal, wordVal);
				if (n != 2)
					reportFailure("malformed memory line in the vector file");
				else
					mem[addrVal] = wordVal;
			end else if (c == "E") begin
				n = $fscanf(fd, "%h %h", regVal, wordVal);
				if (n != 2)
					reportFailure("malformed expected-register line in the vector file");
				else begin
					expReg[regVal[3:0]] = wordVal;
					expValid[regVal[3:0]] = 1'b1;
				end
			end else if (c == "#")
				n = $fgets(lineBuf, fd);   // rest of a comment line
			c = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	// run the image on a register model to get read addresses and timing
	task automatic walkProgram();
		logic [31:0] model [16];
		logic [31:0] word;
		logic [31:0] immExt;
		logic [31:0] loadAddr;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [3:0]  rc;
		int          addr;
		int          count;
		logic        done;
		for (int i = 0; i < 16; i++)
			model[i] = '0;
		expCycles = 0;
		addr = 0;
		count = 0;
		done = 1'b0;
		while (!done) begin
			word = memWord(addr[AddrWidth-1:0]);
			ra = word[26:23];
			rb = word[22:19];
			rc = word[18:15];
			immExt = {{13{word[18]}}, word[18:0]};
			expAddr.push_back(addr[AddrWidth-1:0]);
			case (word[31:27])
				cpuIsaPkg::OpAnd: begin
					model[ra] = model[rb] & model[rc];
					expCycles += 6;
				end
				cpuIsaPkg::OpOr: begin
					model[ra] = model[rb] | model[rc];
					expCycles += 6;
				end
				cpuIsaPkg::OpAndi: begin
					model[ra] = model[rb] & immExt;
					expCycles += 6;
				end
				cpuIsaPkg::OpOri: begin
					model[ra] = model[rb] | immExt;
					expCycles += 6;
				end
				cpuIsaPkg::OpLd: begin
					loadAddr = model[rb] + immExt;
					expAddr.push_back(loadAddr[AddrWidth-1:0]);
					model[ra] = memWord(loadAddr[AddrWidth-1:0]);
					expCycles += 8;
				end
				cpuIsaPkg::OpHalt: begin
					expCycles += 3;
					haltAddr = addr;
					done = 1'b1;
				end
				default: begin
					reportFailure($sformatf("unsupported opcode %b at address %0h in the image",
						word[31:27], addr));
					done = 1'b1;
				end
			endcase
			addr++;
			count++;
			if (count > 4096 && !done) begin
				reportFailure("the program image has no reachable HALT");
				done = 1'b1;
			end
		end
	endtask

	always @(posedge Clock) begin
		if (memRead)
			memData <= memWord(memAddr);   // valid before the MDR load edge
		if (rstN)
			cycleCount <= cycleCount + 1;
	end

	// read pulses, addresses and the halt point sampled mid-cycle
	always @(negedge Clock) begin
		if (rstN) begin
			if (memRead) begin
				if (lastMemRead)
					reportFailure("memRead stayed high for more than one cycle");
				if (haltSeen)
					reportFailure("memRead went high after halted");
				if (readIdx >= expAddr.size())
					reportFailure("memRead issued with no further read expected");
				else if (memAddr !== expAddr[readIdx])
					reportMismatch("memAddr", 32'(memAddr), 32'(expAddr[readIdx]));
				if (readIdx == 0)
					t0Cycle = cycleCount;   // first T0
				readIdx++;
			end
			if (halted && !haltSeen) begin
				haltSeen = 1'b1;
				if (readIdx == 0)
					reportFailure("halted rose before any instruction fetch");
				else if (cycleCount - t0Cycle != expCycles)
					reportMismatch("halted rise, cycles after first T0",
						32'(cycleCount - t0Cycle), 32'(expCycles));
				if (pc !== AddrWidth'(haltAddr + 1))
					reportMismatch("pc", 32'(pc), 32'(haltAddr + 1));
			end
			lastMemRead = memRead;
		end
	end

	always @(negedge Clock) begin
		if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
			reportFailure($sformatf("run did not finish within %0d cycles", timeoutLimit));
			printSummary();
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		memData = '0;
		dbgSel = '0;
		cycleCount = 0;
		t0Cycle = 0;
		readIdx = 0;
		lastMemRead = 1'b0;
		haltSeen = 1'b0;
		mismatchCount = 0;
		failureCount = 0;
		void'($urandom(65752));
		idleGap = 1 + int'($urandom % 10);
		readVectors();
		walkProgram();
		timeoutLimit = expCycles + idleGap + 50;

		repeat (2) @(posedge Clock);
		rstN <= 1'b1;

		@(negedge Clock);
		if (memRead !== 1'b0)
			reportMismatch("memRead", 32'(memRead), 32'd0);
		if (halted !== 1'b0)
			reportMismatch("halted", 32'(halted), 32'd0);
		if (pc !== '0)
			reportMismatch("pc", 32'(pc), 32'd0);
		for (int r = 0; r < 16; r++) begin
			@(posedge Clock);
			dbgSel <= 4'(r);
			@(negedge Clock);
			if (dbgData !== 32'd0)
				reportMismatch($sformatf("dbgData r%0d", r), dbgData, 32'd0);
		end

		repeat (idleGap) @(posedge Clock);
		run <= 1'b1;
		while (!haltSeen)
			@(posedge Clock);

		// register dump while memRead must stay quiet
		for (int n = 0; n < PostHaltCycles; n++) begin
			@(posedge Clock);
			if (n < 16)
				dbgSel <= 4'(n);
			@(negedge Clock);
			if (!halted)
				reportFailure("halted dropped before reset");
			if (n < 16 && expValid[n] && dbgData !== expReg[n])
				reportMismatch($sformatf("dbgData r%0d", n), dbgData, expReg[n]);
		end
		if (readIdx != expAddr.size())
			reportFailure($sformatf("only %0d of %0d expected memory reads were seen",
				readIdx, expAddr.size()));

		printSummary();
		if (mismatchCount + failureCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== verilog/cpuBusTop.sv ====
`timescale 1ns/1ps

module cpuBusTop #(
	parameter int AddrWidth = 16
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 run,
	input  logic [31:0]          memData,
	input  logic [3:0]           dbgSel,
	output logic [AddrWidth-1:0] memAddr,
	output logic                 memRead,
	output logic [AddrWidth-1:0] pc,
	output logic                 halted,
	output logic [31:0]          dbgData
);

	logic [cpuBusPkg::StepWidth-1:0]    step;
	logic [2**cpuBusPkg::StepWidth-1:0] stepOneHot;
	logic                               stepClear;
	logic                               stepAdvance;

	datapathCtrl ctrl ();

	controlSequencer uSequencer (
		.Clock       (Clock),
		.rstN        (rstN),
		.run         (run),
		.ctrl        (ctrl.sequencer),
		.step        (step),
		.stepOneHot  (stepOneHot),
		.stepClear   (stepClear),
		.stepAdvance (stepAdvance),
		.halted      (halted)
	);

	stepCounter uStepCounter (
		.Clock       (Clock),
		.rstN        (rstN),
		.stepClear   (stepClear),
		.stepAdvance (stepAdvance),
		.step        (step),
		.stepOneHot  (stepOneHot)
	);

	busDatapath #(
		.AddrWidth (AddrWidth)
	) uDatapath (
		.Clock   (Clock),
		.rstN    (rstN),
		.ctrl    (ctrl.datapath),
		.memData (memData),
		.dbgSel  (dbgSel),
		.memAddr (memAddr),
		.pc      (pc),
		.mar     (),
		.dbgData (dbgData)
	);

	assign memRead = ctrl.memRead;

endmodule

// ==== verilog/busDatapath.sv ====
`timescale 1ns/1ps

module busDatapath #(
	parameter int AddrWidth = 16
) (
	input  logic                 Clock,
	input  logic                 rstN,
	datapathCtrl.datapath        ctrl,
	input  logic [31:0]          memData,
	input  logic [3:0]           dbgSel,
	output logic [AddrWidth-1:0] memAddr,
	output logic [AddrWidth-1:0] pc,
	output logic [AddrWidth-1:0] mar,
	output logic [31:0]          dbgData
);

	logic [31:0]          bus;
	logic [31:0]          mdr;
	cpuIsaPkg::instrWordT ir;
	logic [3:0]           regAddr;
	logic [31:0]          regData;
	logic [31:0]          immExt;
	logic [31:0]          operandB;
	logic [31:0]          zOut;

	always_comb begin
		case (ctrl.busSrc)
			cpuBusPkg::BusPc:  bus = 32'(pc);    // zero-extended address
			cpuBusPkg::BusMdr: bus = mdr;
			cpuBusPkg::BusZ:   bus = zOut;
			cpuBusPkg::BusReg: bus = regData;
			default:           bus = '0;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			pc <= '0;
		else if (ctrl.pcIn)
			pc <= bus[AddrWidth-1:0];
		else if (ctrl.incPc)
			pc <= pc + 1'b1;
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			mar <= '0;
		else if (ctrl.marIn)
			mar <= bus[AddrWidth-1:0];
	end

	// the address leaves with the MAR load so memory answers in the next step
	assign memAddr = ctrl.marIn ? bus[AddrWidth-1:0] : mar;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			mdr <= '0;
		else if (ctrl.mdrIn)
			mdr <= memData;
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			ir <= '0;
		else if (ctrl.irIn)
			ir <= bus;
	end

	// during the IR load the sequencer already decodes the word in MDR
	assign ctrl.irWord = ctrl.irIn ? cpuIsaPkg::instrWordT'(mdr) : ir;

	always_comb begin
		case (ctrl.regSel)
			cpuBusPkg::RegB: regAddr = ir.r.rb;
			cpuBusPkg::RegC: regAddr = ir.r.rc;
			default:         regAddr = ir.r.ra;
		endcase
	end

	assign immExt = {{13{ir.i.imm[18]}}, ir.i.imm};
	assign operandB = ctrl.useImm ? immExt : bus;

	registerFile uRegFile (
		.Clock     (Clock),
		.rstN      (rstN),
		.writeEn   (ctrl.regIn),
		.writeAddr (regAddr),
		.readAddr  (regAddr),
		.writeData (bus),
		.dbgSel    (dbgSel),
		.readData  (regData),
		.dbgData   (dbgData)
	);

	aluStage uAlu (
		.Clock    (Clock),
		.rstN     (rstN),
		.yIn      (ctrl.yIn),
		.zIn      (ctrl.zIn),
		.aluOp    (ctrl.aluOp),
		.busIn    (bus),
		.operandB (operandB),
		.zOut     (zOut)
	);

endmodule

// ==== verilog/aluStage.sv ====
`timescale 1ns/1ps

module aluStage (
	input  logic             Clock,
	input  logic             rstN,
	input  logic             yIn,
	input  logic             zIn,
	input  cpuBusPkg::aluOpT aluOp,
	input  logic [31:0]      busIn,
	input  logic [31:0]      operandB,
	output logic [31:0]      zOut
);

	logic [31:0] y;
	logic [31:0] result;

	// Y holds the A operand while the bus carries B
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			y <= '0;
		else if (yIn)
			y <= busIn;
	end

	always_comb begin
		case (aluOp)
			cpuBusPkg::AluAnd: result = y & operandB;
			cpuBusPkg::AluOr:  result = y | operandB;
			cpuBusPkg::AluAdd: result = y + operandB;   // LD address
			default:           result = '0;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			zOut <= '0;
		else if (zIn)
			zOut <= result;
	end

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input  logic        Clock,
	input  logic        rstN,
	input  logic        writeEn,
	input  logic [3:0]  writeAddr,
	input  logic [3:0]  readAddr,
	input  logic [31:0] writeData,
	input  logic [3:0]  dbgSel,
	output logic [31:0] readData,
	output logic [31:0] dbgData
);

	logic [31:0] regs [16];

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (writeEn)
			regs[writeAddr] <= writeData;
	end

	assign readData = regs[readAddr];   // onto the bus
	assign dbgData = regs[dbgSel];      // observation only

endmodule

// ==== verilog/controlSequencer.sv ====
`timescale 1ns/1ps

module controlSequencer (
	input  logic                                Clock,
	input  logic                                rstN,
	input  logic                                run,
	datapathCtrl.sequencer                      ctrl,
	input  logic [cpuBusPkg::StepWidth-1:0]     step,
	input  logic [2**cpuBusPkg::StepWidth-1:0]  stepOneHot,
	output logic                                stepClear,
	output logic                                stepAdvance,
	output logic                                halted
);

	localparam int Sw = cpuBusPkg::StepWidth;
	localparam logic [Sw-1:0] StepDecode = Sw'(2);  // IR load and HALT decode
	localparam logic [Sw-1:0] StepAluEnd = Sw'(5);
	localparam logic [Sw-1:0] StepLdMem = Sw'(5);
	localparam logic [Sw-1:0] StepLdEnd = Sw'(7);

	localparam logic [1:0] Idle = 2'd0;
	localparam logic [1:0] Running = 2'd1;
	localparam logic [1:0] Halt = 2'd2;

	logic [1:0]         state;
	logic               running;
	cpuIsaPkg::opcodeT  opcode;
	logic               isLd;
	logic               isImm;
	logic               isAlu;
	logic               isHalt;
	logic               lastStep;
	logic [3:0]         srcHot;

	assign running = (state == Running);
	assign opcode = ctrl.irWord.r.opcode;
	assign isLd = (opcode == cpuIsaPkg::OpLd);
	assign isImm = (opcode == cpuIsaPkg::OpAndi) || (opcode == cpuIsaPkg::OpOri);
	assign isAlu = isImm || (opcode == cpuIsaPkg::OpAnd) || (opcode == cpuIsaPkg::OpOr);
	assign isHalt = (opcode == cpuIsaPkg::OpHalt);

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			state <= Idle;
		else begin
			case (state)
				Idle:    if (run) state <= Running;
				Running: if (stepOneHot[2] && isHalt) state <= Halt;
				default: state <= state;   // stays halted until reset
			endcase
		end
	end

	assign halted = (state == Halt);

	// HALT and unknown opcodes finish in T2
	assign lastStep = (isAlu && step == StepAluEnd) ||
		(isLd && step == StepLdEnd) ||
		(!isAlu && !isLd && step == StepDecode);
	assign stepClear = !running || lastStep;
	assign stepAdvance = running && !lastStep;

	// the datapath also bypasses MDR onto irWord with this strobe
	assign ctrl.irIn = running && stepOneHot[2];
	assign ctrl.pcIn = 1'b0;   // no branches so PC only counts

	always_comb begin
		ctrl.busSrc = cpuBusPkg::BusNone;
		ctrl.regSel = cpuBusPkg::RegA;
		ctrl.regIn = 1'b0;
		ctrl.incPc = 1'b0;
		ctrl.marIn = 1'b0;
		ctrl.mdrIn = 1'b0;
		ctrl.yIn = 1'b0;
		ctrl.zIn = 1'b0;
		ctrl.useImm = 1'b0;
		ctrl.aluOp = cpuBusPkg::AluAdd;
		ctrl.memRead = 1'b0;
		if (running) begin
			case (1'b1)
				stepOneHot[0]: begin   // fetch address
					ctrl.busSrc = cpuBusPkg::BusPc;
					ctrl.marIn = 1'b1;
					ctrl.incPc = 1'b1;
					ctrl.memRead = 1'b1;
				end
				stepOneHot[1]: ctrl.mdrIn = 1'b1;
				stepOneHot[2]: ctrl.busSrc = cpuBusPkg::BusMdr;
				stepOneHot[3]: begin
					if (isAlu || isLd) begin
						ctrl.busSrc = cpuBusPkg::BusReg;
						ctrl.regSel = cpuBusPkg::RegB;
						ctrl.yIn = 1'b1;
					end
				end
				stepOneHot[4]: begin
					if (isAlu || isLd) begin
						ctrl.zIn = 1'b1;
						if (isImm || isLd)
							ctrl.useImm = 1'b1;
						else begin
							ctrl.busSrc = cpuBusPkg::BusReg;
							ctrl.regSel = cpuBusPkg::RegC;
						end
						case (opcode)
							cpuIsaPkg::OpAnd, cpuIsaPkg::OpAndi: ctrl.aluOp = cpuBusPkg::AluAnd;
							cpuIsaPkg::OpOr, cpuIsaPkg::OpOri:   ctrl.aluOp = cpuBusPkg::AluOr;
							default:                             ctrl.aluOp = cpuBusPkg::AluAdd;
						endcase
					end
				end
				stepOneHot[5]: begin
					ctrl.busSrc = cpuBusPkg::BusZ;
					if (isLd) begin            // effective address out
						ctrl.marIn = 1'b1;
						ctrl.memRead = 1'b1;
					end else
						ctrl.regIn = 1'b1;     // ALU result to Ra
				end
				stepOneHot[6]: ctrl.mdrIn = isLd;
				stepOneHot[7]: begin
					if (isLd) begin
						ctrl.busSrc = cpuBusPkg::BusMdr;
						ctrl.regIn = 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	assign srcHot = {
		ctrl.busSrc == cpuBusPkg::BusPc,
		ctrl.busSrc == cpuBusPkg::BusMdr,
		ctrl.busSrc == cpuBusPkg::BusZ,
		ctrl.busSrc == cpuBusPkg::BusReg
	};

	// any block loading from the bus sees exactly one driver
	oneBusSource: assert property (
		@(posedge Clock) disable iff (!rstN)
		(ctrl.marIn || ctrl.irIn || ctrl.yIn || ctrl.regIn) |-> $onehot(srcHot)
	);

	memReadStep: assert property (
		@(posedge Clock) disable iff (!rstN)
		ctrl.memRead |-> (step == '0) || (step == StepLdMem && isLd)
	);

endmodule

// ==== verilog/stepCounter.sv ====
`timescale 1ns/1ps

module stepCounter (
	input  logic                                  Clock,
	input  logic                                  rstN,
	input  logic                                  stepClear,
	input  logic                                  stepAdvance,
	output logic [cpuBusPkg::StepWidth-1:0]       step,
	output logic [2**cpuBusPkg::StepWidth-1:0]    stepOneHot
);

	localparam int Sw = cpuBusPkg::StepWidth;
	localparam logic [Sw-1:0] LastStep = '1;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			step <= '0;
		else if (stepClear)         // clear wins over advance
			step <= '0;
		else if (stepAdvance)
			step <= step + 1'b1;
	end

	always_comb begin
		stepOneHot = '0;
		stepOneHot[step] = 1'b1;
	end

	// the sequencer clears after T7 so the count never rolls over
	noWrap: assert property (
		@(posedge Clock) disable iff (!rstN)
		(stepAdvance && !stepClear) |-> (step != LastStep)
	);

endmodule

// ==== verilog/datapathCtrl.sv ====
`timescale 1ns/1ps

interface datapathCtrl;

	cpuBusPkg::busSrcT    busSrc;
	cpuBusPkg::regSelT    regSel;
	logic                 regIn;    // Ra takes the bus
	logic                 pcIn;
	logic                 incPc;
	logic                 marIn;
	logic                 mdrIn;    // MDR takes memData
	logic                 irIn;
	logic                 yIn;
	logic                 zIn;
	logic                 useImm;   // ALU B input from the immediate
	cpuBusPkg::aluOpT     aluOp;
	logic                 memRead;
	cpuIsaPkg::instrWordT irWord;   // current instruction back to the sequencer

	modport sequencer (
		output busSrc, regSel, regIn, pcIn, incPc, marIn, mdrIn, irIn,
		output yIn, zIn, useImm, aluOp, memRead,
		input  irWord
	);

	modport datapath (
		input  busSrc, regSel, regIn, pcIn, incPc, marIn, mdrIn, irIn,
		input  yIn, zIn, useImm, aluOp, memRead,
		output irWord
	);

endinterface

// ==== verilog/cpuBusPkg.sv ====
package cpuBusPkg;

	// steps T0 to T7
	localparam int StepWidth = 3;

	// which block drives the shared bus this step
	typedef enum logic [2:0] {
		BusNone,
		BusPc,
		BusMdr,
		BusZ,
		BusReg
	} busSrcT;

	typedef enum logic [1:0] {
		AluAnd,
		AluOr,
		AluAdd
	} aluOpT;

	// register field of the IR that addresses the register file
	typedef enum logic [1:0] {
		RegA,
		RegB,
		RegC
	} regSelT;

endpackage

// ==== verilog/cpuIsaPkg.sv ====
package cpuIsaPkg;

	// 5-bit major opcode in bits 31:27
	typedef enum logic [4:0] {
		OpLd   = 5'b00000,
		OpAnd  = 5'b01010,
		OpOr   = 5'b01011,
		OpAndi = 5'b01100,
		OpOri  = 5'b01101,
		OpHalt = 5'b11111
	} opcodeT;

	typedef struct packed {
		opcodeT      opcode;
		logic [3:0]  ra;    // destination
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [14:0] unused;
	} rFormatT;

	typedef struct packed {
		opcodeT      opcode;
		logic [3:0]  ra;
		logic [3:0]  rb;    // base register for LD
		logic [18:0] imm;   // sign-extended before use
	} iFormatT;

	// both views share opcode, ra and rb at the same bit positions
	typedef union packed {
		rFormatT r;
		iFormatT i;
	} instrWordT;

endpackage
